// ==== cpu.f ====
+incdir+.
cpuPkg.sv
hazardIf.sv
fetchStage.sv
decodeStage.sv
executeStage.sv
memWbStage.sv
hazardUnit.sv
cpuTop.sv
tbCpu.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the pipeline testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f cpu.f --top-module tbCpu -o tbCpu
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tbCpu > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "Test OK" "$LOG"; then
	exit 0
fi
echo "pass message not found in $LOG"
exit 1

// ==== tbIsaModel.svh ====
`ifndef TB_ISA_MODEL_SVH
`define TB_ISA_MODEL_SVH

// data memory word for a byte address, wraps on the depth
function automatic int wordIndex(input logic [`CPU_XLEN-1:0] addr);
	return int'(addr[`CPU_XLEN-1:2] % (`CPU_XLEN-2)'(`CPU_DMEM_WORDS));
endfunction

// runs prog from address 0 up to the closing self jump
// every write to a nonzero register is queued as an expected retire
function automatic int runModel();
	logic [`CPU_XLEN-1:0] rf [`CPU_NREGS];
	logic [`CPU_XLEN-1:0] mem [`CPU_DMEM_WORDS];
	instrT in;
	int pc;
	int nextPc;
	int steps;
	logic [`CPU_XLEN-1:0] a;
	logic [`CPU_XLEN-1:0] b;
	logic [`CPU_XLEN-1:0] sext;
	logic [`CPU_XLEN-1:0] zext;
	logic [`CPU_XLEN-1:0] res;
	logic [RW-1:0] dst;
	logic wr;

	foreach (rf[k]) begin
		rf[k] = '0;
	end
	foreach (mem[k]) begin
		mem[k] = '0;
	end
	expReg.delete();
	expData.delete();
	pc = 0;
	steps = 0;
	// forward-only control flow, so the loop ends within PROG_LEN steps
	while (pc != PROG_LEN - 1 && steps < PROG_LEN) begin
		in = prog[pc];
		a = rf[in.r.rs];
		b = rf[in.r.rt];
		sext = {{(`CPU_XLEN-16){in.i.imm[15]}}, in.i.imm};
		zext = {{(`CPU_XLEN-16){1'b0}}, in.i.imm};
		wr = 1'b1;
		dst = in.r.rt;
		res = '0;
		nextPc = pc + 1;
		case (in.r.opcode)
			OP_RTYPE: begin
				dst = in.r.rd;
				case (in.r.funct)
					F_ADD: res = a + b;
					F_SUB: res = a - b;
					F_AND: res = a & b;
					F_OR: res = a | b;
					F_SLT: res = ($signed(a) < $signed(b)) ? `CPU_XLEN'd1 : `CPU_XLEN'd0;
					default: wr = 1'b0;
				endcase
			end
			OP_ADDI: res = a + sext;
			OP_ANDI: res = a & zext;
			OP_ORI: res = a | zext;
			OP_LUI: res = {in.i.imm, {(`CPU_XLEN-16){1'b0}}};
			OP_LW: res = mem[wordIndex(a + sext)];
			OP_SW: begin
				wr = 1'b0;
				mem[wordIndex(a + sext)] = b;
			end
			OP_BEQ, OP_BNE: begin
				wr = 1'b0;
				// taken when equality matches the opcode, no delay slot
				if ((a == b) == (in.r.opcode == OP_BEQ)) begin
					nextPc = pc + 1 + int'($signed(in.i.imm));
				end
			end
			OP_J, OP_JAL: begin
				wr = (in.r.opcode == OP_JAL);
				dst = RW'(`CPU_LINK_REG);
				res = `CPU_XLEN'((pc + 1) * 4);
				nextPc = int'(in.r[25:0]);
			end
			default: wr = 1'b0;
		endcase
		if (wr && dst != '0) begin
			rf[dst] = res;
			expReg.push_back(dst);
			expData.push_back(res);
		end
		pc = nextPc;
		steps++;
	end
	return expReg.size();
endfunction

`endif

// ==== tbCpu.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpuParams.svh"

module tbCpu;
	import cpuPkg::*;

	localparam int RW = $clog2(`CPU_NREGS);
	localparam int PROG_LEN = 200;
	localparam int NUM_TESTS = 4;
	localparam int RESET_CYCLES = 10;
	localparam int DRAIN_CYCLES = 20;
	// a stall or a bubble costs at most two cycles, so 20 per instruction is ample
	localparam int WATCHDOG_CYCLES = NUM_TESTS * PROG_LEN * 20;

	logic CLK = 1'b0;
	logic rst = 1'b1;
	logic [`CPU_XLEN-1:0] imemAddr;
	logic [31:0] imemData;
	logic retireValid;
	logic [RW-1:0] retireReg;
	logic [`CPU_XLEN-1:0] retireData;

	integer seed;
	instrT prog [PROG_LEN];
	logic [RW-1:0] expReg [$];
	logic [`CPU_XLEN-1:0] expData [$];
	int expCount = 0;
	int retired = 0;
	logic [`CPU_XLEN-3:0] fetchWord;

	`include "tbIsaModel.svh"

	cpuTop dut (
		.CLK(CLK), .rst(rst),
		.imemAddr(imemAddr), .imemData(imemData),
		.retireValid(retireValid), .retireReg(retireReg), .retireData(retireData)
	);

	always #50 CLK = ~CLK;

	// instruction memory, answers in the same cycle
	assign fetchWord = imemAddr[`CPU_XLEN-1:2];
	always_comb begin
		if (fetchWord < (`CPU_XLEN-2)'(PROG_LEN)) begin
			imemData = prog[fetchWord[7:0]];
		end else begin
			imemData = '0;
		end
	end

	function automatic int randBelow(input int n);
		return int'($unsigned($random(seed)) % $unsigned(n));
	endfunction

	// small register set keeps dependencies dense, r31 also read after jal
	function automatic logic [RW-1:0] pickReg();
		int r;
		r = randBelow(9);
		if (r == 8) begin
			return RW'(`CPU_LINK_REG);
		end
		return RW'(r);
	endfunction

	function automatic functT pickFunct();
		case (randBelow(5))
			0: return F_ADD;
			1: return F_SUB;
			2: return F_AND;
			3: return F_OR;
			default: return F_SLT;
		endcase
	endfunction

	function automatic instrT makeR(input functT f, input logic [RW-1:0] rd,
		input logic [RW-1:0] rs, input logic [RW-1:0] rt);
		instrT in;
		in = '0;
		in.r.opcode = OP_RTYPE;
		in.r.rs = rs;
		in.r.rt = rt;
		in.r.rd = rd;
		in.r.funct = f;
		return in;
	endfunction

	function automatic instrT makeI(input opcodeT op, input logic [RW-1:0] rs,
		input logic [RW-1:0] rt, input logic [15:0] imm);
		instrT in;
		in = '0;
		in.i.opcode = op;
		in.i.rs = rs;
		in.i.rt = rt;
		in.i.imm = imm;
		return in;
	endfunction

	function automatic instrT makeJ(input opcodeT op, input int target);
		instrT in;
		in = {op, 26'(target)};
		return in;
	endfunction

	// word offsets 0 to 15, base is r0 half of the time so stores and loads meet
	function automatic instrT makeMem(input opcodeT op);
		logic [RW-1:0] base;
		base = (randBelow(2) == 0) ? RW'(0) : pickReg();
		return makeI(op, base, pickReg(), 16'(randBelow(16) * 4));
	endfunction

	function automatic void genProgram();
		int kind;
		int hop;
		int room;
		for (int i = 0; i < PROG_LEN - 1; i++) begin
			kind = randBelow(16);
			// targets stay forward and inside the program
			room = PROG_LEN - 2 - i;
			hop = randBelow(4);
			if (hop > room) begin
				hop = room;
			end
			case (kind)
				0, 1, 2, 3, 4: prog[i] = makeR(pickFunct(), pickReg(), pickReg(), pickReg());
				5, 6: prog[i] = makeI(OP_ADDI, pickReg(), pickReg(), 16'(randBelow(32) - 16));
				7: prog[i] = makeI(OP_ANDI, pickReg(), pickReg(), 16'($random(seed)));
				8: prog[i] = makeI(OP_ORI, pickReg(), pickReg(), 16'($random(seed)));
				9: prog[i] = makeI(OP_LUI, RW'(0), pickReg(), 16'($random(seed)));
				10, 11: prog[i] = makeMem(OP_LW);
				12: prog[i] = makeMem(OP_SW);
				13: prog[i] = makeI(OP_BEQ, pickReg(), pickReg(), 16'(hop));
				14: prog[i] = makeI(OP_BNE, pickReg(), pickReg(), 16'(hop));
				default: prog[i] = makeJ((randBelow(2) == 0) ? OP_J : OP_JAL, i + 1 + hop);
			endcase
		end
		// closing self jump, never retires
		prog[PROG_LEN-1] = makeJ(OP_J, PROG_LEN - 1);
	endfunction

	task automatic reportFailure(input string why);
		$display("%s", why);
		$display("Test FAILED");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic checkReg(input logic [RW-1:0] got, input logic [RW-1:0] want, input int idx);
		if (got !== want) begin
			reportFailure($sformatf("Mismatch retireReg: got 0x%h expected 0x%h at retire %0d",
				got, want, idx));
		end
	endtask

	task automatic checkData(input logic [`CPU_XLEN-1:0] got, input logic [`CPU_XLEN-1:0] want,
		input int idx);
		if (got !== want) begin
			reportFailure($sformatf("Mismatch retireData: got 0x%h expected 0x%h at retire %0d",
				got, want, idx));
		end
	endtask

	// outputs settle after the rising edge, so look at them on the falling one
	always @(negedge CLK) begin
		if (rst) begin
			if (retireValid === 1'b1) begin
				reportFailure("a retire appeared while reset was held");
			end
		end else if (retireValid) begin
			if (retired >= expCount) begin
				reportFailure($sformatf("retire to register %0d beyond the expected count of %0d",
					retireReg, expCount));
			end else begin
				checkReg(retireReg, expReg[retired], retired);
				checkData(retireData, expData[retired], retired);
				retired++;
			end
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge CLK);
		reportFailure($sformatf("timeout after %0d cycles with %0d of %0d retires seen",
			WATCHDOG_CYCLES, retired, expCount));
	end

	initial begin
		seed = 28;
		for (int t = 0; t < NUM_TESTS; t++) begin
			@(negedge CLK);
			rst <= 1'b1;
			genProgram();
			expCount = runModel();
			retired = 0;
			repeat (RESET_CYCLES) @(negedge CLK);
			rst <= 1'b0;
			while (retired < expCount) begin
				@(negedge CLK);
			end
			// the closing self jump must stay silent
			repeat (DRAIN_CYCLES) @(negedge CLK);
		end
		$display("Test OK");
		$finish;
	end

endmodule

`default_nettype wire

// ==== cpuTop.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpuParams.svh"

module cpuTop (
	input logic CLK,
	input logic rst,
	output logic [`CPU_XLEN-1:0] imemAddr,
	input logic [31:0] imemData,
	output logic retireValid,
	output logic [$clog2(`CPU_NREGS)-1:0] retireReg,
	output logic [`CPU_XLEN-1:0] retireData
);
	import cpuPkg::*;

	localparam int RW = $clog2(`CPU_NREGS);

	logic redirect;
	logic [`CPU_XLEN-1:0] redirectPc;
	instrT instrD;
	logic [`CPU_XLEN-1:0] pcPlus4D;

	ctrlT ctrlE;
	logic [`CPU_XLEN-1:0] rsValE;
	logic [`CPU_XLEN-1:0] rtValE;
	logic [`CPU_XLEN-1:0] immE;
	logic [RW-1:0] destE;
	logic [`CPU_XLEN-1:0] pcPlus4E;

	ctrlT ctrlM;
	logic [`CPU_XLEN-1:0] memResult;
	logic [`CPU_XLEN-1:0] storeDataM;
	logic [RW-1:0] destM;

	logic [RW-1:0] wbReg;
	logic [`CPU_XLEN-1:0] wbData;
	logic wbWrite;

	hazardIf hz ();

	fetchStage fetch (
		.CLK(CLK), .rst(rst), .hz(hz),
		.redirect(redirect), .redirectPc(redirectPc),
		.imemAddr(imemAddr), .imemData(imemData),
		.instrD(instrD), .pcPlus4D(pcPlus4D)
	);

	decodeStage decode (
		.CLK(CLK), .rst(rst), .hz(hz),
		.instrD(instrD), .pcPlus4D(pcPlus4D),
		.wbReg(wbReg), .wbData(wbData), .wbWrite(wbWrite),
		.memResult(memResult),
		.redirect(redirect), .redirectPc(redirectPc),
		.ctrlE(ctrlE), .rsValE(rsValE), .rtValE(rtValE),
		.immE(immE), .destE(destE), .pcPlus4E(pcPlus4E)
	);

	executeStage execute (
		.CLK(CLK), .rst(rst), .hz(hz),
		.ctrlE(ctrlE), .rsValE(rsValE), .rtValE(rtValE),
		.immE(immE), .destE(destE), .pcPlus4E(pcPlus4E),
		.memResult(memResult), .wbData(wbData),
		.ctrlM(ctrlM), .storeDataM(storeDataM), .destM(destM)
	);

	memWbStage memWb (
		.CLK(CLK), .rst(rst), .hz(hz),
		.ctrlM(ctrlM), .memResult(memResult), .storeDataM(storeDataM), .destM(destM),
		.wbReg(wbReg), .wbData(wbData), .wbWrite(wbWrite),
		.retireValid(retireValid), .retireReg(retireReg), .retireData(retireData)
	);

	hazardUnit hazard (
		.CLK(CLK), .rst(rst), .hz(hz)
	);

endmodule

`default_nettype wire

// ==== hazardUnit.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpuParams.svh"

module hazardUnit (
	input logic CLK,
	input logic rst,
	hazardIf.unit hz
);
	import cpuPkg::*;

	localparam int RW = $clog2(`CPU_NREGS);

	logic lwStall;
	logic branchStall;
	logic stall;

	// a set regWrite implies a nonzero destination
	function automatic fwdSelT pickExec(input logic [RW-1:0] src);
		if (hz.regWriteM && hz.destM == src) begin
			return FWD_MEM;
		end
		if (hz.regWriteW && hz.destW == src) begin
			return FWD_WB;
		end
		return FWD_NONE;
	endfunction

	// load in execute feeding the instruction in decode
	assign lwStall = hz.memToRegE && hz.regWriteE &&
		(hz.destE == hz.rsD || hz.destE == hz.rtD);

	// branch waits on a producer in execute or a load in memory
	assign branchStall = hz.branchD && (
		(hz.regWriteE && (hz.destE == hz.rsD || hz.destE == hz.rtD)) ||
		(hz.memToRegM && hz.regWriteM && (hz.destM == hz.rsD || hz.destM == hz.rtD)));

	assign stall = lwStall || branchStall;

	assign hz.stallF = stall;
	assign hz.stallD = stall;
	assign hz.flushE = stall;

	always_comb begin
		hz.fwdAE = pickExec(hz.rsE);
		hz.fwdBE = pickExec(hz.rtE);
	end

	// a load in memory is never forwarded to decode
	assign hz.fwdAD = (hz.regWriteM && !hz.memToRegM && hz.destM == hz.rsD) ?
		FWD_MEM : FWD_NONE;
	assign hz.fwdBD = (hz.regWriteM && !hz.memToRegM && hz.destM == hz.rtD) ?
		FWD_MEM : FWD_NONE;

	// a stalled consumer never sees its producer in execute
	stallBubble: assert property (@(posedge CLK) disable iff (rst)
		hz.stallD |=> !hz.regWriteE);

endmodule

`default_nettype wire

// ==== memWbStage.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpuParams.svh"

module memWbStage (
	input logic CLK,
	input logic rst,
	hazardIf.stage hz,
	input cpuPkg::ctrlT ctrlM,
	input logic [`CPU_XLEN-1:0] memResult,
	input logic [`CPU_XLEN-1:0] storeDataM,
	input logic [$clog2(`CPU_NREGS)-1:0] destM,
	output logic [$clog2(`CPU_NREGS)-1:0] wbReg,
	output logic [`CPU_XLEN-1:0] wbData,
	output logic wbWrite,
	output logic retireValid,
	output logic [$clog2(`CPU_NREGS)-1:0] retireReg,
	output logic [`CPU_XLEN-1:0] retireData
);
	import cpuPkg::*;

	localparam int AW = $clog2(`CPU_DMEM_WORDS);

	logic [`CPU_XLEN-1:0] dmem [`CPU_DMEM_WORDS];
	logic [AW-1:0] wordIdx;
	logic [`CPU_XLEN-1:0] loadData;

	// word address wraps on the memory depth
	assign wordIdx = memResult[AW+1:2];
	assign loadData = dmem[wordIdx];

	always_ff @(posedge CLK) begin
		if (rst) begin
			for (int i = 0; i < `CPU_DMEM_WORDS; i++) begin
				dmem[i] <= '0;
			end
		end else if (ctrlM.memWrite) begin
			dmem[wordIdx] <= storeDataM;
		end
	end

	always_ff @(posedge CLK) begin
		if (rst) begin
			wbWrite <= 1'b0;
		end else begin
			wbWrite <= ctrlM.regWrite;
		end
	end

	// result chosen before the writeback register
	always_ff @(posedge CLK) begin
		wbReg <= destM;
		wbData <= ctrlM.memToReg ? loadData : memResult;
	end

	assign hz.destW = wbReg;
	assign hz.regWriteW = wbWrite;

	// one retire per register write
	assign retireValid = wbWrite && (wbReg != '0);
	assign retireReg = wbReg;
	assign retireData = wbData;

endmodule

`default_nettype wire

// ==== executeStage.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpuParams.svh"

module executeStage (
	input logic CLK,
	input logic rst,
	hazardIf.stage hz,
	input cpuPkg::ctrlT ctrlE,
	input logic [`CPU_XLEN-1:0] rsValE,
	input logic [`CPU_XLEN-1:0] rtValE,
	input logic [`CPU_XLEN-1:0] immE,
	input logic [$clog2(`CPU_NREGS)-1:0] destE,
	input logic [`CPU_XLEN-1:0] pcPlus4E,
	output logic [`CPU_XLEN-1:0] memResult,
	input logic [`CPU_XLEN-1:0] wbData,
	output cpuPkg::ctrlT ctrlM,
	output logic [`CPU_XLEN-1:0] storeDataM,
	output logic [$clog2(`CPU_NREGS)-1:0] destM
);
	import cpuPkg::*;

	logic [`CPU_XLEN-1:0] srcA;
	logic [`CPU_XLEN-1:0] fwdB;
	logic [`CPU_XLEN-1:0] srcB;
	logic [`CPU_XLEN-1:0] aluOut;
	logic [`CPU_XLEN-1:0] resultE;

	// memory stage is newer than writeback
	always_comb begin
		unique case (hz.fwdAE)
			FWD_MEM: srcA = memResult;
			FWD_WB: srcA = wbData;
			default: srcA = rsValE;
		endcase
		unique case (hz.fwdBE)
			FWD_MEM: fwdB = memResult;
			FWD_WB: fwdB = wbData;
			default: fwdB = rtValE;
		endcase
	end

	// immediate already extended in decode
	assign srcB = (ctrlE.aluSrc == SRC_REG) ? fwdB : immE;

	always_comb begin
		unique case (ctrlE.aluOp)
			ALU_ADD: aluOut = srcA + srcB;
			ALU_SUB: aluOut = srcA - srcB;
			ALU_AND: aluOut = srcA & srcB;
			ALU_OR: aluOut = srcA | srcB;
			ALU_SLT: aluOut = {{(`CPU_XLEN-1){1'b0}}, $signed(srcA) < $signed(srcB)};
			default: aluOut = '0;
		endcase
	end

	// jal link, then lui zero pad, else ALU
	assign resultE = ctrlE.link ? pcPlus4E : (ctrlE.outSelect ? immE : aluOut);

	assign hz.destE = destE;
	assign hz.regWriteE = ctrlE.regWrite;
	assign hz.memToRegE = ctrlE.memToReg;
	assign hz.destM = destM;
	assign hz.regWriteM = ctrlM.regWrite;
	assign hz.memToRegM = ctrlM.memToReg;

	always_ff @(posedge CLK) begin
		if (rst) begin
			ctrlM <= '0;
		end else begin
			ctrlM <= ctrlE;
		end
	end

	always_ff @(posedge CLK) begin
		memResult <= resultE;
		storeDataM <= fwdB;
		destM <= destE;
	end

endmodule

`default_nettype wire

// ==== decodeStage.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpuParams.svh"

module decodeStage (
	input logic CLK,
	input logic rst,
	hazardIf.stage hz,
	input cpuPkg::instrT instrD,
	input logic [`CPU_XLEN-1:0] pcPlus4D,
	input logic [$clog2(`CPU_NREGS)-1:0] wbReg,
	input logic [`CPU_XLEN-1:0] wbData,
	input logic wbWrite,
	input logic [`CPU_XLEN-1:0] memResult,
	output logic redirect,
	output logic [`CPU_XLEN-1:0] redirectPc,
	output cpuPkg::ctrlT ctrlE,
	output logic [`CPU_XLEN-1:0] rsValE,
	output logic [`CPU_XLEN-1:0] rtValE,
	output logic [`CPU_XLEN-1:0] immE,
	output logic [$clog2(`CPU_NREGS)-1:0] destE,
	output logic [`CPU_XLEN-1:0] pcPlus4E
);
	import cpuPkg::*;

	localparam int RW = $clog2(`CPU_NREGS);

	logic [`CPU_XLEN-1:0] regs [`CPU_NREGS];
	ctrlT ctrlD;
	logic [RW-1:0] destD;
	logic [RW-1:0] srcRs;
	logic [RW-1:0] srcRt;
	logic isBeq;
	logic isBne;
	logic isJump;
	logic [`CPU_XLEN-1:0] immD;
	logic [`CPU_XLEN-1:0] aVal;
	logic [`CPU_XLEN-1:0] bVal;
	logic taken;

	// same-cycle writeback shows through to the read
	function automatic logic [`CPU_XLEN-1:0] readReg(input logic [RW-1:0] idx);
		if (idx == '0) begin
			return '0;
		end
		if (wbWrite && wbReg == idx) begin
			return wbData;
		end
		return regs[idx];
	endfunction

	always_comb begin
		ctrlD = '0;
		isBeq = 1'b0;
		isBne = 1'b0;
		isJump = 1'b0;
		unique case (instrD.r.opcode)
			OP_RTYPE: begin
				ctrlD.regDst = 1'b1;
				ctrlD.regWrite = 1'b1;
				case (instrD.r.funct)
					F_ADD: ctrlD.aluOp = ALU_ADD;
					F_SUB: ctrlD.aluOp = ALU_SUB;
					F_AND: ctrlD.aluOp = ALU_AND;
					F_OR: ctrlD.aluOp = ALU_OR;
					F_SLT: ctrlD.aluOp = ALU_SLT;
					// bubbles and unknown functs write nothing
					default: ctrlD.regWrite = 1'b0;
				endcase
			end
			OP_ADDI: begin
				ctrlD.regWrite = 1'b1;
				ctrlD.aluSrc = SRC_SIGN;
			end
			OP_ANDI: begin
				ctrlD.regWrite = 1'b1;
				ctrlD.aluSrc = SRC_ZERO;
				ctrlD.aluOp = ALU_AND;
			end
			OP_ORI: begin
				ctrlD.regWrite = 1'b1;
				ctrlD.aluSrc = SRC_ZERO;
				ctrlD.aluOp = ALU_OR;
			end
			OP_LUI: begin
				ctrlD.regWrite = 1'b1;
				ctrlD.outSelect = 1'b1;
			end
			OP_LW: begin
				ctrlD.regWrite = 1'b1;
				ctrlD.memToReg = 1'b1;
				ctrlD.aluSrc = SRC_SIGN;
			end
			OP_SW: begin
				ctrlD.memWrite = 1'b1;
				ctrlD.aluSrc = SRC_SIGN;
			end
			OP_BEQ: isBeq = 1'b1;
			OP_BNE: isBne = 1'b1;
			OP_J: isJump = 1'b1;
			OP_JAL: begin
				isJump = 1'b1;
				ctrlD.link = 1'b1;
				ctrlD.regWrite = 1'b1;
			end
			default: ;
		endcase

		if (ctrlD.link) begin
			destD = RW'(`CPU_LINK_REG);
		end else if (ctrlD.regDst) begin
			destD = instrD.r.rd;
		end else begin
			destD = instrD.r.rt;
		end
		// writes to register 0 are dropped here
		if (destD == '0) begin
			ctrlD.regWrite = 1'b0;
		end
	end

	// only real source fields reach the hazard unit
	assign srcRs = isJump ? '0 : instrD.r.rs;
	assign srcRt = (instrD.r.opcode == OP_RTYPE || isBeq || isBne || ctrlD.memWrite) ?
		instrD.r.rt : '0;

	always_comb begin
		if (ctrlD.outSelect) begin
			immD = {instrD.i.imm, {(`CPU_XLEN-16){1'b0}}};
		end else if (ctrlD.aluSrc == SRC_ZERO) begin
			immD = {{(`CPU_XLEN-16){1'b0}}, instrD.i.imm};
		end else begin
			immD = {{(`CPU_XLEN-16){instrD.i.imm[15]}}, instrD.i.imm};
		end
	end

	always_comb begin
		aVal = (hz.fwdAD == FWD_MEM) ? memResult : readReg(instrD.r.rs);
		bVal = (hz.fwdBD == FWD_MEM) ? memResult : readReg(instrD.r.rt);
	end

	// branch resolves in decode so a redirect costs one slot
	assign taken = (isBeq && aVal == bVal) || (isBne && aVal != bVal);
	assign redirect = taken || isJump;
	assign redirectPc = isJump ?
		{pcPlus4D[`CPU_XLEN-1:28], instrD.r.rs, instrD.r.rt, instrD.r.rd,
			instrD.r.shamt, instrD.r.funct, 2'b00} :
		pcPlus4D + {{(`CPU_XLEN-18){instrD.i.imm[15]}}, instrD.i.imm, 2'b00};

	assign hz.rsD = srcRs;
	assign hz.rtD = srcRt;
	assign hz.branchD = isBeq || isBne;

	always_ff @(posedge CLK) begin
		if (rst) begin
			for (int i = 0; i < `CPU_NREGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wbWrite && wbReg != '0) begin
			regs[wbReg] <= wbData;
		end
	end

	always_ff @(posedge CLK) begin
		if (rst || hz.flushE) begin
			ctrlE <= '0;
			destE <= '0;
			hz.rsE <= '0;
			hz.rtE <= '0;
		end else begin
			ctrlE <= ctrlD;
			destE <= destD;
			hz.rsE <= srcRs;
			hz.rtE <= srcRt;
		end
	end

	always_ff @(posedge CLK) begin
		rsValE <= aVal;
		rtValE <= bVal;
		immE <= immD;
		pcPlus4E <= pcPlus4D;
	end

	// writeback never targets register 0
	noZeroWrite: assert property (@(posedge CLK) disable iff (rst)
		wbWrite |-> wbReg != '0);

endmodule

`default_nettype wire

// ==== fetchStage.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpuParams.svh"

module fetchStage (
	input logic CLK,
	input logic rst,
	hazardIf.stage hz,
	input logic redirect,
	input logic [`CPU_XLEN-1:0] redirectPc,
	output logic [`CPU_XLEN-1:0] imemAddr,
	input cpuPkg::instrT imemData,
	output cpuPkg::instrT instrD,
	output logic [`CPU_XLEN-1:0] pcPlus4D
);
	import cpuPkg::*;

	logic [`CPU_XLEN-1:0] pc;
	logic [`CPU_XLEN-1:0] pcPlus4F;
	logic [`CPU_XLEN-1:0] pcNext;

	assign imemAddr = pc;
	assign pcPlus4F = pc + `CPU_XLEN'd4;

	// decode redirect wins over sequential fetch
	assign pcNext = redirect ? redirectPc : pcPlus4F;

	always_ff @(posedge CLK) begin
		if (rst) begin
			pc <= '0;
		end else if (!hz.stallF) begin
			pc <= pcNext;
		end
	end

	// fetched word is dropped when decode redirects
	always_ff @(posedge CLK) begin
		if (rst) begin
			instrD <= '0;
		end else if (!hz.stallD) begin
			instrD <= redirect ? instrT'('0) : imemData;
			pcPlus4D <= pcPlus4F;
		end
	end

	// targets are built from shifted word offsets
	pcAligned: assert property (@(posedge CLK) disable iff (rst) pc[1:0] == 2'b00);

endmodule

`default_nettype wire

// ==== hazardIf.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpuParams.svh"

interface hazardIf;
	import cpuPkg::*;

	localparam int RW = $clog2(`CPU_NREGS);

	// register indices seen by each stage
	logic [RW-1:0] rsD;
	logic [RW-1:0] rtD;
	logic [RW-1:0] rsE;
	logic [RW-1:0] rtE;
	logic [RW-1:0] destE;
	logic [RW-1:0] destM;
	logic [RW-1:0] destW;

	logic branchD;
	logic regWriteE;
	logic memToRegE;
	logic regWriteM;
	logic memToRegM;
	logic regWriteW;

	// decisions from the hazard unit
	logic stallF;
	logic stallD;
	logic flushE;
	fwdSelT fwdAE;
	fwdSelT fwdBE;
	fwdSelT fwdAD;
	fwdSelT fwdBD;

	modport stage (
		output rsD, rtD, rsE, rtE, destE, destM, destW,
		output branchD, regWriteE, memToRegE, regWriteM, memToRegM, regWriteW,
		input stallF, stallD, flushE, fwdAE, fwdBE, fwdAD, fwdBD
	);

	modport unit (
		input rsD, rtD, rsE, rtE, destE, destM, destW,
		input branchD, regWriteE, memToRegE, regWriteM, memToRegM, regWriteW,
		output stallF, stallD, flushE, fwdAE, fwdBE, fwdAD, fwdBD
	);

endinterface

`default_nettype wire

// ==== cpuPkg.sv ====
`default_nettype none

package cpuPkg;

	typedef enum logic [5:0] {
		OP_RTYPE = 6'h00,
		OP_J     = 6'h02,
		OP_JAL   = 6'h03,
		OP_BEQ   = 6'h04,
		OP_BNE   = 6'h05,
		OP_ADDI  = 6'h08,
		OP_ANDI  = 6'h0c,
		OP_ORI   = 6'h0d,
		OP_LUI   = 6'h0f,
		OP_LW    = 6'h23,
		OP_SW    = 6'h2b
	} opcodeT;

	typedef enum logic [5:0] {
		F_ADD = 6'h20,
		F_SUB = 6'h22,
		F_AND = 6'h24,
		F_OR  = 6'h25,
		F_SLT = 6'h2a
	} functT;

	// R view, the jump target is its low 26 bits
	typedef struct packed {
		opcodeT opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		functT funct;
	} rInstrT;

	typedef struct packed {
		opcodeT opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [15:0] imm;
	} iInstrT;

	typedef union packed {
		rInstrT r;
		iInstrT i;
	} instrT;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_SLT
	} aluOpT;

	// operand B source, also picks how decode extends the immediate
	typedef enum logic [1:0] {
		SRC_REG  = 2'b00,
		SRC_SIGN = 2'b01,
		SRC_ZERO = 2'b10
	} aluSrcT;

	typedef struct packed {
		logic regWrite;
		logic memToReg;
		logic memWrite;
		aluSrcT aluSrc;
		logic outSelect;
		logic regDst;
		logic link;
		aluOpT aluOp;
	} ctrlT;

	typedef enum logic [1:0] {
		FWD_NONE = 2'b00,
		FWD_WB   = 2'b01,
		FWD_MEM  = 2'b10
	} fwdSelT;

endpackage

`default_nettype wire

// ==== cpuParams.svh ====
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// data and address width
`define CPU_XLEN 32

// architectural registers
`define CPU_NREGS 32

// data memory depth in words
`define CPU_DMEM_WORDS 256

// jal link target
`define CPU_LINK_REG 31

`endif
